/* source/riscv_v_pkg.sv */
//############################################################
// Widths and codes shared by the vector bitwise unit
// Op code 2'd3 is unused and every lane decodes it as XOR
// SEW codes select 1, 2, 4 or 8 bytes per element
//############################################################

package riscv_v_pkg;

    // One datapath lane carries one byte
    localparam int unsigned BYTE_WIDTH = 8;

    typedef logic [BYTE_WIDTH-1:0] byte_t;

    // Bitwise operation code
    typedef logic [1:0] bw_op_t;

    localparam bw_op_t BW_OP_AND = 2'd0;
    localparam bw_op_t BW_OP_OR  = 2'd1;
    localparam bw_op_t BW_OP_XOR = 2'd2;

    // Element size code, as in vtype.vsew
    typedef logic [1:0] sew_t;

    localparam sew_t SEW_8  = 2'd0;
    localparam sew_t SEW_16 = 2'd1;
    localparam sew_t SEW_32 = 2'd2;
    localparam sew_t SEW_64 = 2'd3;

    // Bytes covered by one element of the given size
    function automatic int unsigned sew_bytes(sew_t sew);
        case (sew)
            SEW_8:   return 1;
            SEW_16:  return 2;
            SEW_32:  return 4;
            SEW_64:  return 8;
            default: return 1;
        endcase
    endfunction

endpackage

/* source/riscv_v_bw_lane.sv */
//############################################################
// Single byte lane of the bitwise unit, combinational
// Unused op code falls through to XOR
//############################################################

`timescale 1ns/100ps

module riscv_v_bw_lane (
    input  riscv_v_pkg::bw_op_t op,
    input  riscv_v_pkg::byte_t  a,
    input  riscv_v_pkg::byte_t  b,
    output riscv_v_pkg::byte_t  s
);

    import riscv_v_pkg::*;

    // Operation select for one byte pair
    always_comb begin
        case (op)
            BW_OP_AND: begin
                s = a & b;
            end
            BW_OP_OR: begin
                s = a | b;
            end
            // BW_OP_XOR and the spare code
            default: begin
                s = a ^ b;
            end
        endcase
    end

endmodule

/* source/riscv_v_bw_operand_prep.sv */
//############################################################
// Operand routing for the bitwise lanes, fully combinational
// Reduction chain flows from high lanes down to element 0
// Invalid srcb bytes become the identity of op
//############################################################

`timescale 1ns/100ps

module riscv_v_bw_operand_prep #(
    parameter int NUM_BYTES = 8
) (
    input  riscv_v_pkg::bw_op_t                  op,
    input  riscv_v_pkg::sew_t                    sew,
    input  logic                                 is_reduct,
    input  riscv_v_pkg::byte_t [NUM_BYTES-1:0]   srca,
    input  riscv_v_pkg::byte_t [NUM_BYTES-1:0]   srcb,
    input  logic [NUM_BYTES-1:0]                 srcb_valid,
    // Combinational lane results, read back for the chain
    input  riscv_v_pkg::byte_t [NUM_BYTES-1:0]   lane_s,
    output riscv_v_pkg::byte_t [NUM_BYTES-1:0]   lane_a,
    output riscv_v_pkg::byte_t [NUM_BYTES-1:0]   lane_b
);

    import riscv_v_pkg::*;

    // Identity of the operation
    // AND keeps a byte with all ones, OR and XOR with zero
    byte_t b_identity;

    assign b_identity = (op == BW_OP_AND) ? {BYTE_WIDTH{1'b1}} : '0;

    for (genvar i = 0; i < NUM_BYTES; i++) begin : gen_prep
        // Chain source of this lane, one entry per SEW code
        byte_t red_src [4];

        for (genvar k = 0; k < 4; k++) begin : gen_red_src
            // Element size in bytes for SEW code k
            localparam int ELEM = 1 << k;

            if (i + ELEM < NUM_BYTES) begin : gen_chain
                // Same byte position, one element higher
                assign red_src[k] = lane_s[i+ELEM];
            end else begin : gen_scalar
                // Top element starts the chain with the scalar
                // Matching byte of srca element 0
                assign red_src[k] = srca[i+ELEM-NUM_BYTES];
            end
        end

        // Element-wise ops take srca as is
        // Only higher lanes are read, so no loop exists for any sew
        assign lane_a[i] = is_reduct ? red_src[sew] : srca[i];

        // Masked bytes leave the result as srca op identity
        assign lane_b[i] = srcb_valid[i] ? srcb[i] : b_identity;
    end

endmodule

/* source/riscv_v_bw_result_reg.sv */
//############################################################
// Output stage, one cycle after in_valid
// Reduction keeps only element 0, upper bytes read zero
// No back-pressure, result_valid lasts a single cycle
//############################################################

`timescale 1ns/100ps

module riscv_v_bw_result_reg #(
    parameter int NUM_BYTES = 8
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 in_valid,
    input  logic                                 is_reduct,
    input  riscv_v_pkg::sew_t                    sew,
    input  riscv_v_pkg::byte_t [NUM_BYTES-1:0]   lane_s,
    output riscv_v_pkg::byte_t [NUM_BYTES-1:0]   result,
    output logic                                 result_valid
);

    import riscv_v_pkg::*;

    // Lane results after the reduction mask
    byte_t [NUM_BYTES-1:0] masked;

    // Element 0 spans the low sew_bytes lanes
    always_comb begin
        for (int i = 0; i < NUM_BYTES; i++) begin
            if (is_reduct && (i >= sew_bytes(sew))) begin
                masked[i] = '0;
            end else begin
                masked[i] = lane_s[i];
            end
        end
    end

    // Word is captured only on an accepted operation
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result       <= '0;
            result_valid <= 1'b0;
        end else begin
            // Strobe follows in_valid by one cycle
            result_valid <= in_valid;
            if (in_valid) begin
                result <= masked;
            end
        end
    end

endmodule

/* source/riscv_v_bw_unit.sv */
//############################################################
// Bitwise block of the vector ALU, AND OR XOR and reductions
// NUM_BYTES must be a power of two and at least 8
// One op per cycle, result one cycle later, no back-pressure
//############################################################

`timescale 1ns/100ps

module riscv_v_bw_unit #(
    parameter int NUM_BYTES = 8
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    // One-cycle strobe per operation
    input  logic                                 in_valid,
    input  riscv_v_pkg::bw_op_t                  op,
    input  riscv_v_pkg::sew_t                    sew,
    input  logic                                 is_reduct,
    input  riscv_v_pkg::byte_t [NUM_BYTES-1:0]   srca,
    input  riscv_v_pkg::byte_t [NUM_BYTES-1:0]   srcb,
    input  logic [NUM_BYTES-1:0]                 srcb_valid,
    output riscv_v_pkg::byte_t [NUM_BYTES-1:0]   result,
    output logic                                 result_valid
);

    import riscv_v_pkg::*;

    // Width check at elaboration
    if ((NUM_BYTES < 8) || ((NUM_BYTES & (NUM_BYTES - 1)) != 0)) begin : gen_bad_width
        $error("NUM_BYTES must be a power of two, at least 8");
    end

    // Per-lane operands and combinational results
    byte_t [NUM_BYTES-1:0] lane_a;
    byte_t [NUM_BYTES-1:0] lane_b;
    byte_t [NUM_BYTES-1:0] lane_s;

    riscv_v_bw_operand_prep #(
        .NUM_BYTES (NUM_BYTES)
    ) u_operand_prep (
        .op         (op),
        .sew        (sew),
        .is_reduct  (is_reduct),
        .srca       (srca),
        .srcb       (srcb),
        .srcb_valid (srcb_valid),
        .lane_s     (lane_s),
        .lane_a     (lane_a),
        .lane_b     (lane_b)
    );

    // One lane per byte of the datapath word
    for (genvar i = 0; i < NUM_BYTES; i++) begin : gen_lane
        riscv_v_bw_lane u_lane (
            .op (op),
            .a  (lane_a[i]),
            .b  (lane_b[i]),
            .s  (lane_s[i])
        );
    end

    riscv_v_bw_result_reg #(
        .NUM_BYTES (NUM_BYTES)
    ) u_result_reg (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .is_reduct    (is_reduct),
        .sew          (sew),
        .lane_s       (lane_s),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

/* test/riscv_v_bw_clock_gen.sv */
//############################################################
// Testbench clock and active low reset
// Reset is released a short delay after the last reset edge
//############################################################

`timescale 1ns/100ps

module riscv_v_bw_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 3,
    parameter int RELEASE_NS   = 10
) (
    output logic clk,
    output logic rst_n
);

    // Free running clock, first rising edge at half a period
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // Reset held over the first RESET_CYCLES rising edges
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(RELEASE_NS) rst_n = 1'b1;
    end

endmodule

/* test/riscv_v_bw_unit_properties.sv */
//############################################################
// Reference model and checks, bound into the bitwise unit
// Expected word is held one cycle and compared on the strobe
// First failure is kept for the testbench to report
//############################################################

`timescale 1ns/100ps

module riscv_v_bw_unit_properties #(
    parameter int NUM_BYTES = 8
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 in_valid,
    input  riscv_v_pkg::bw_op_t                  op,
    input  riscv_v_pkg::sew_t                    sew,
    input  logic                                 is_reduct,
    input  riscv_v_pkg::byte_t [NUM_BYTES-1:0]   srca,
    input  riscv_v_pkg::byte_t [NUM_BYTES-1:0]   srcb,
    input  logic [NUM_BYTES-1:0]                 srcb_valid,
    input  riscv_v_pkg::byte_t [NUM_BYTES-1:0]   result,
    input  logic                                 result_valid
);

    import riscv_v_pkg::*;

    typedef byte_t [NUM_BYTES-1:0] word_t;

    // First failure seen, read by the testbench top
    logic  fail_seen = 1'b0;
    string fail_signal;
    word_t fail_expected;
    word_t fail_actual;

    // Model output for the current inputs
    word_t model_word;
    // Model output held until the result strobe
    word_t exp_result;

    // One byte of AND, OR or XOR, spare code acts as XOR
    function automatic byte_t byte_op(bw_op_t f_op, byte_t a, byte_t b);
        if (f_op == BW_OP_AND) begin
            return a & b;
        end else if (f_op == BW_OP_OR) begin
            return a | b;
        end
        return a ^ b;
    endfunction

    // Expected word from the element-wise and reduction rules
    function automatic word_t reference_word(bw_op_t f_op, sew_t f_sew, logic red,
                                             word_t a, word_t b,
                                             logic [NUM_BYTES-1:0] v);
        word_t eff_b;
        word_t w;
        byte_t ident;
        byte_t acc;
        int    elem;
        ident = (f_op == BW_OP_AND) ? 8'hFF : 8'h00;
        for (int i = 0; i < NUM_BYTES; i++) begin
            eff_b[i] = v[i] ? b[i] : ident;
        end
        w = '0;
        if (!red) begin
            for (int i = 0; i < NUM_BYTES; i++) begin
                w[i] = byte_op(f_op, a[i], eff_b[i]);
            end
        end else begin
            // Element of 1, 2, 4 or 8 bytes
            elem = 1 << f_sew;
            // Scalar folded with each srcb element, byte by byte
            for (int j = 0; j < elem; j++) begin
                acc = a[j];
                for (int k = 0; k < NUM_BYTES; k += elem) begin
                    acc = byte_op(f_op, acc, eff_b[k+j]);
                end
                w[j] = acc;
            end
        end
        return w;
    endfunction

    assign model_word = reference_word(op, sew, is_reduct, srca, srcb, srcb_valid);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_result <= '0;
        end else if (in_valid) begin
            exp_result <= model_word;
        end
    end

    // Keeps only the first failure
    task automatic note_failure(input string name, input word_t expected, input word_t actual);
        if (!fail_seen) begin
            fail_signal   = name;
            fail_expected = expected;
            fail_actual   = actual;
            fail_seen     = 1'b1;
        end
    endtask

    // Strobe follows in_valid by one cycle
    a_valid_after_in: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |=> result_valid)
    else begin
        note_failure("result_valid", 1, 0);
        $error("result_valid low one cycle after in_valid");
    end

    // No strobe without an operation the cycle before
    a_no_spurious_valid: assert property (@(posedge clk) disable iff (!rst_n)
        !in_valid |=> !result_valid)
    else begin
        note_failure("result_valid", 0, 1);
        $error("result_valid high without a preceding in_valid");
    end

    // Async reset, checked away from the rising edge
    a_valid_low_in_reset: assert property (@(negedge clk)
        !rst_n |-> !result_valid)
    else begin
        note_failure("result_valid", 0, 1);
        $error("result_valid high during reset");
    end

    // Result word cleared by the same reset
    a_result_zero_in_reset: assert property (@(negedge clk)
        !rst_n |-> (result == '0))
    else begin
        note_failure("result", '0, $sampled(result));
        $error("result not zero during reset");
    end

    // Result word against the held model word
    a_result_match: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid |-> (result == exp_result))
    else begin
        note_failure("result", $sampled(exp_result), $sampled(result));
        $error("result 0x%0h, expected 0x%0h", $sampled(result), $sampled(exp_result));
    end

endmodule

/* test/riscv_v_bw_unit_tb.sv */
//############################################################
// Testbench of the vector bitwise unit, NUM_BYTES of 8
// Bound assertions check, stimulus only reaches each case
// Random data from $urandom with a fixed seed
//############################################################

`timescale 1ns/100ps

module riscv_v_bw_unit_tb;

    import riscv_v_pkg::*;

    localparam int NUM_BYTES     = 8;
    localparam int CLK_PERIOD    = 100;
    localparam int DRIVE_DELAY   = 10;
    localparam int RANDOM_SEED   = 32;
    // Element-wise 6, masked 6, reductions 12, masked reductions 15
    localparam int NUM_DIRECTED  = 39;
    localparam int NUM_RANDOM    = 200;
    // Covers reset, idle gaps and the drain at the end
    localparam int MARGIN_CYCLES = 40;
    localparam int WATCHDOG_NS   = (NUM_DIRECTED + NUM_RANDOM + MARGIN_CYCLES) * CLK_PERIOD;

    localparam bw_op_t OPS [3] = '{BW_OP_AND, BW_OP_OR, BW_OP_XOR};

    typedef byte_t [NUM_BYTES-1:0] word_t;

    logic                 clk;
    logic                 rst_n;
    logic                 in_valid;
    bw_op_t               op;
    sew_t                 sew;
    logic                 is_reduct;
    word_t                srca;
    word_t                srcb;
    logic [NUM_BYTES-1:0] srcb_valid;
    word_t                result;
    logic                 result_valid;

    riscv_v_bw_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (3),
        .RELEASE_NS   (DRIVE_DELAY)
    ) u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    riscv_v_bw_unit #(
        .NUM_BYTES (NUM_BYTES)
    ) u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .op           (op),
        .sew          (sew),
        .is_reduct    (is_reduct),
        .srca         (srca),
        .srcb         (srcb),
        .srcb_valid   (srcb_valid),
        .result       (result),
        .result_valid (result_valid)
    );

    bind riscv_v_bw_unit riscv_v_bw_unit_properties #(
        .NUM_BYTES (NUM_BYTES)
    ) u_props (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .op           (op),
        .sew          (sew),
        .is_reduct    (is_reduct),
        .srca         (srca),
        .srcb         (srcb),
        .srcb_valid   (srcb_valid),
        .result       (result),
        .result_valid (result_valid)
    );

    function automatic word_t random_word();
        word_t w;
        for (int i = 0; i < NUM_BYTES; i++) begin
            w[i] = byte_t'($urandom);
        end
        return w;
    endfunction

    function automatic logic [NUM_BYTES-1:0] random_mask();
        logic [NUM_BYTES-1:0] m;
        for (int i = 0; i < NUM_BYTES; i++) begin
            m[i] = $urandom % 2;
        end
        return m;
    endfunction

    // One operation, in_valid stays high until the next call or idle
    task automatic issue_op(input bw_op_t t_op, input sew_t t_sew, input logic t_red,
                            input word_t t_a, input word_t t_b,
                            input logic [NUM_BYTES-1:0] t_v);
        @(posedge clk);
        #(DRIVE_DELAY);
        in_valid   = 1'b1;
        op         = t_op;
        sew        = t_sew;
        is_reduct  = t_red;
        srca       = t_a;
        srcb       = t_b;
        srcb_valid = t_v;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            in_valid = 1'b0;
        end
    endtask

    // Reports the first assertion failure
    initial begin : failure_watch
        wait (u_dut.u_props.fail_seen === 1'b1);
        $display("ERROR: %s expected 0x%0h actual 0x%0h", u_dut.u_props.fail_signal,
                 u_dut.u_props.fail_expected, u_dut.u_props.fail_actual);
        $display("TB FAILED");
        $fatal(1, "assertion failed");
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        // Live all-ones operation through reset, outputs must stay clear
        in_valid   = 1'b1;
        op         = BW_OP_OR;
        sew        = SEW_8;
        is_reduct  = 1'b0;
        srca       = '1;
        srcb       = '1;
        srcb_valid = '1;
        void'($urandom(RANDOM_SEED));
        wait (rst_n === 1'b1);
        idle_cycles(2);
        // Element-wise, all bytes valid
        foreach (OPS[o]) begin
            issue_op(OPS[o], SEW_8, 1'b0, 64'hF0F0_3C3C_A5A5_0FF0, 64'hFF00_F00F_5A5A_1234, '1);
            issue_op(OPS[o], SEW_32, 1'b0, random_word(), random_word(), '1);
        end
        idle_cycles(2);
        // Masked element-wise, invalid bytes give srca back
        foreach (OPS[o]) begin
            issue_op(OPS[o], SEW_16, 1'b0, random_word(), random_word(), 8'b1010_0101);
            issue_op(OPS[o], SEW_8, 1'b0, random_word(), random_word(), '0);
        end
        idle_cycles(2);
        // Reductions at every element size
        foreach (OPS[o]) begin
            for (int s = 0; s < 4; s++) begin
                issue_op(OPS[o], sew_t'(s), 1'b1, random_word(), random_word(), '1);
            end
        end
        idle_cycles(1);
        // Reductions with invalid bytes, none valid as the last case
        foreach (OPS[o]) begin
            for (int s = 0; s < 4; s++) begin
                issue_op(OPS[o], sew_t'(s), 1'b1, random_word(), random_word(), random_mask());
            end
            issue_op(OPS[o], SEW_8, 1'b1, random_word(), random_word(), '0);
        end
        idle_cycles(2);
        // Back-to-back random operations, spare op code included
        for (int n = 0; n < NUM_RANDOM; n++) begin
            issue_op(bw_op_t'($urandom % 4), sew_t'($urandom % 4), logic'($urandom % 2),
                     random_word(), random_word(), random_mask());
        end
        idle_cycles(3);
        if (u_dut.u_props.fail_seen) begin
            $display("TB FAILED");
            $fatal(1, "assertion failures during the run");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

/* sim.f */
source/riscv_v_pkg.sv
source/riscv_v_bw_lane.sv
source/riscv_v_bw_operand_prep.sv
source/riscv_v_bw_result_reg.sv
source/riscv_v_bw_unit.sv
test/riscv_v_bw_clock_gen.sv
test/riscv_v_bw_unit_properties.sv
test/riscv_v_bw_unit_tb.sv

/* Bender.yml */
package:
  name: riscv_v_bw_unit

sources:
  # RTL of the bitwise unit, package first
  - files:
      - source/riscv_v_pkg.sv
      - source/riscv_v_bw_lane.sv
      - source/riscv_v_bw_operand_prep.sv
      - source/riscv_v_bw_result_reg.sv
      - source/riscv_v_bw_unit.sv

  # Testbench, properties and clock
  - target: test
    files:
      - test/riscv_v_bw_clock_gen.sv
      - test/riscv_v_bw_unit_properties.sv
      - test/riscv_v_bw_unit_tb.sv
